//--- sources.f
+incdir+rtl
rtl/mul_pkg.sv
rtl/pipe_stage_ctrl.sv
rtl/mul_issue.sv
rtl/mul_stage.sv
rtl/mul_retire.sv
rtl/mul_pipe_top.sv
tests/mul_pipe_props.sv
tests/mul_pipe_tb.sv

//--- tests/mul_pipe_tb.sv
`timescale 1ns/1ps
`include "mul_consts.svh"

module mul_pipe_tb
  import mul_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 5;
  localparam int LAT_CYCLES      = 6;
  localparam int N_STREAM        = 12;
  localparam int N_BP            = 10;
  localparam int N_REQ           = 1 + N_STREAM + N_BP + 5 + 5;
  localparam int WATCHDOG_CYCLES = 400 + 40 * N_REQ;
  localparam int DRAIN_LIMIT     = 100;
  // Output ready pattern used while the stalled pipe is released
  localparam logic [5:0] RAGGED_READY = 6'b101001;

  logic     clk;
  logic     rst_n;
  logic     flush_i;
  logic     cancel_i;
  logic     req_valid_i;
  mul_req_t req_i;
  logic     req_ready_o;
  logic     res_valid_o;
  mul_rsp_t res_o;
  logic     res_ready_i;

  int error_cnt    = 0;
  int check_cnt    = 0;
  int cycle_cnt    = 0;
  int last_res_cyc = 0;
  int stream_cnt   = 0;
  int max_gap      = 0;
  logic [31:0]           lcg_state = 32'd83029;
  logic [`MUL_TAG_W-1:0] next_tag  = '0;
  mul_rsp_t              exp_q [$];

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  mul_pipe_top i_mul_pipe_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .cancel_i   (cancel_i),
    .req_valid_i(req_valid_i),
    .req_i      (req_i),
    .req_ready_o(req_ready_o),
    .res_valid_o(res_valid_o),
    .res_o      (res_o),
    .res_ready_i(res_ready_i)
  );

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  // Reference result straight from a times b
  function automatic mul_rsp_t expected_rsp(input mul_req_t r);
    logic [2*`MUL_W-1:0] prod;
    mul_rsp_t            rsp;
    prod       = {{`MUL_W{1'b0}}, r.a} * {{`MUL_W{1'b0}}, r.b};
    rsp.op     = r.op;
    rsp.tag    = r.tag;
    rsp.result = (r.op == MUL_HI) ? prod[2*`MUL_W-1:`MUL_W] : prod[`MUL_W-1:0];
    return rsp;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    error_cnt++;
    $display("CHECK FAILED %s: expected 0x%0h, got 0x%0h", name, exp, got);
  endtask

  task automatic check_result(input mul_rsp_t got);
    mul_rsp_t exp;
    if (exp_q.size() == 0) begin
      error_cnt++;
      $display("Unexpected result with tag 0x%0h at cycle %0d", got.tag, cycle_cnt);
    end else begin
      exp = exp_q.pop_front();
      check_cnt++;
      if (got.tag !== exp.tag) report_mismatch("res_o.tag", exp.tag, got.tag);
      if (got.op !== exp.op) report_mismatch("res_o.op", exp.op, got.op);
      if (got.result !== exp.result) report_mismatch("res_o.result", exp.result, got.result);
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Response monitor, sampled on the transfer edge
  always @(posedge clk) begin
    if (rst_n && res_valid_o && res_ready_i) begin
      check_result(res_o);
      if (stream_cnt > 0 && (cycle_cnt - last_res_cyc) > max_gap) begin
        max_gap = cycle_cnt - last_res_cyc;
      end
      stream_cnt++;
      last_res_cyc = cycle_cnt;
    end
  end

  // Called on a falling edge; returns on the falling edge after the transfer
  task automatic send_req(input mul_op_e op, input logic [`MUL_W-1:0] a,
                          input logic [`MUL_W-1:0] b);
    mul_req_t r;
    r.op        = op;
    r.tag       = next_tag;
    r.a         = a;
    r.b         = b;
    next_tag    = next_tag + 1'b1;
    req_i       = r;
    req_valid_i = 1'b1;
    #1;
    while (!req_ready_o) begin
      @(negedge clk);
      #1;
    end
    @(posedge clk);
    exp_q.push_back(expected_rsp(r));
    @(negedge clk);
  endtask

  task automatic send_random();
    mul_op_e           op;
    logic [`MUL_W-1:0] a;
    logic [`MUL_W-1:0] b;
    logic [15:0]       sel;
    sel = next_rand();
    op  = sel[0] ? MUL_HI : MUL_LO;
    a   = next_rand();
    b   = next_rand();
    send_req(op, a, b);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      error_cnt++;
      $display("Timed out with %0d results still outstanding", exp_q.size());
      exp_q.delete();
    end
    // Quiet cycles so a duplicated result shows up as unexpected
    repeat (8) @(negedge clk);
  endtask

  task automatic reset_and_latency();
    int lat;
    if (res_valid_o !== 1'b0) report_mismatch("res_valid_o", 1'b0, res_valid_o);
    if (req_ready_o !== 1'b1) report_mismatch("req_ready_o", 1'b1, req_ready_o);
    send_req(MUL_LO, 16'hbeef, 16'h1234);
    req_valid_i = 1'b0;
    lat = 0;
    while (res_valid_o !== 1'b1 && lat < DRAIN_LIMIT) begin
      lat++;
      @(negedge clk);
    end
    if (lat != LAT_CYCLES) report_mismatch("latency", LAT_CYCLES, lat);
    wait_drain();
  endtask

  task automatic back_to_back_stream();
    stream_cnt = 0;
    max_gap    = 0;
    for (int i = 0; i < N_STREAM; i++) begin
      send_random();
    end
    req_valid_i = 1'b0;
    wait_drain();
    if (stream_cnt != N_STREAM) report_mismatch("result count", N_STREAM, stream_cnt);
    if (max_gap != 1) report_mismatch("result spacing", 1, max_gap);
  endtask

  task automatic output_backpressure();
    res_ready_i = 1'b0;
    fork
      begin
        for (int i = 0; i < N_BP; i++) begin
          send_random();
        end
        req_valid_i = 1'b0;
      end
      begin
        // Long enough for the buffer and every stage to fill
        repeat (14) @(negedge clk);
        #1;
        if (req_ready_o !== 1'b0) report_mismatch("req_ready_o", 1'b0, req_ready_o);
        if (res_valid_o !== 1'b1) report_mismatch("res_valid_o", 1'b1, res_valid_o);
        for (int i = 0; i < 6; i++) begin
          @(negedge clk);
          res_ready_i = RAGGED_READY[i];
        end
        @(negedge clk);
        res_ready_i = 1'b1;
      end
    join
    wait_drain();
  endtask

  task automatic flush_in_flight();
    for (int i = 0; i < 3; i++) begin
      send_random();
    end
    req_valid_i = 1'b0;
    flush_i     = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    exp_q.delete();
    repeat (12) @(negedge clk);
    send_random();
    send_random();
    req_valid_i = 1'b0;
    wait_drain();
  endtask

  task automatic cancel_head();
    // First request is the fresh head when the cancel arrives
    send_random();
    cancel_i = 1'b1;
    void'(exp_q.pop_back());
    send_random();
    cancel_i = 1'b0;
    send_random();
    req_valid_i = 1'b0;
    wait_drain();
    send_random();
    send_random();
    req_valid_i = 1'b0;
    cancel_i    = 1'b1;
    flush_i     = 1'b1;
    @(negedge clk);
    cancel_i = 1'b0;
    flush_i  = 1'b0;
    exp_q.delete();
    repeat (12) @(negedge clk);
  endtask

  initial begin
    rst_n       = 1'b0;
    flush_i     = 1'b0;
    cancel_i    = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    res_ready_i = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    reset_and_latency();
    back_to_back_stream();
    output_backpressure();
    flush_in_flight();
    cancel_head();
    $display("Summary: %0d results checked, %0d errors", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- tests/mul_pipe_props.sv
`timescale 1ns/1ps

module mul_pipe_props
  import mul_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     req_ready_i,
  input logic     res_valid_i,
  input mul_rsp_t res_i,
  input logic     res_ready_i
);

  // A held response stays put until the consumer takes it
  res_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_i))
    else $error("res_valid_o or res_o changed while res_ready_i was low");

  ready_after_reset_a: assert property (@(posedge clk) !rst_n |=> req_ready_i)
    else $error("req_ready_o is low after a reset edge");

  valid_low_in_reset_a: assert property (@(posedge clk) !rst_n |=> !res_valid_i)
    else $error("res_valid_o is high after a reset edge");

endmodule

bind mul_pipe_top mul_pipe_props i_mul_pipe_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .req_ready_i(req_ready_o),
  .res_valid_i(res_valid_o),
  .res_i      (res_o),
  .res_ready_i(res_ready_i)
);

//--- rtl/mul_pipe_top.sv
`timescale 1ns/1ps
`include "mul_consts.svh"

module mul_pipe_top
  import mul_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush_i,
  input  logic     cancel_i,
  input  logic     req_valid_i,
  input  mul_req_t req_i,
  output logic     req_ready_o,
  output logic     res_valid_o,
  output mul_rsp_t res_o,
  input  logic     res_ready_i
);

  // Link k feeds stage k; the last link feeds the retire unit
  logic     link_valid [`MUL_STAGES+1];
  logic     link_ready [`MUL_STAGES+1];
  mul_tok_t link_tok   [`MUL_STAGES+1];
  logic     iss_bubble;

  mul_issue i_issue (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .cancel_i    (cancel_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .tok_valid_o (link_valid[0]),
    .tok_bubble_o(iss_bubble),
    .tok_o       (link_tok[0]),
    .tok_ready_i (link_ready[0])
  );

  for (genvar k = 0; k < `MUL_STAGES; k++) begin : g_stage
    logic bubble;

    // Only stage 0 sees cancelled entries
    if (k == 0) begin : g_head
      assign bubble = iss_bubble;
    end else begin : g_tail
      assign bubble = 1'b0;
    end

    mul_stage i_stage (
      .clk     (clk),
      .rst_n   (rst_n),
      .flush_i (flush_i),
      .bubble_i(bubble),
      .valid_i (link_valid[k]),
      .tok_i   (link_tok[k]),
      .ready_o (link_ready[k]),
      .valid_o (link_valid[k+1]),
      .tok_o   (link_tok[k+1]),
      .ready_i (link_ready[k+1])
    );
  end

  mul_retire i_retire (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (link_valid[`MUL_STAGES]),
    .tok_i      (link_tok[`MUL_STAGES]),
    .ready_o    (link_ready[`MUL_STAGES]),
    .res_valid_o(res_valid_o),
    .res_o      (res_o),
    .res_ready_i(res_ready_i)
  );

endmodule

//--- rtl/mul_retire.sv
`timescale 1ns/1ps
`include "mul_consts.svh"

module mul_retire
  import mul_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     valid_i,
  input  mul_tok_t tok_i,
  output logic     ready_o,
  output logic     res_valid_o,
  output mul_rsp_t res_o,
  input  logic     res_ready_i
);

  logic              valid_q;
  mul_rsp_t          rsp_q;
  logic              load;
  logic [`MUL_W-1:0] half;

  assign ready_o = !valid_q || res_ready_i;
  assign load    = valid_i && ready_o;

  always_comb begin
    case (tok_i.op)
      MUL_HI:  half = tok_i.acc[2*`MUL_W-1:`MUL_W];
      default: half = tok_i.acc[`MUL_W-1:0];
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (res_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rsp_q.op     <= tok_i.op;
      rsp_q.tag    <= tok_i.tag;
      rsp_q.result <= half;
    end
  end

  assign res_valid_o = valid_q;
  assign res_o       = rsp_q;

endmodule

//--- rtl/mul_stage.sv
`timescale 1ns/1ps
`include "mul_consts.svh"

module mul_stage
  import mul_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush_i,
  input  logic     bubble_i,
  input  logic     valid_i,
  input  mul_tok_t tok_i,
  output logic     ready_o,
  output logic     valid_o,
  output mul_tok_t tok_o,
  input  logic     ready_i
);

  logic                  advance;
  mul_tok_t              tok_q;
  logic [`MUL_SLICE-1:0] slice;
  logic [2*`MUL_W-1:0]   part;

  pipe_stage_ctrl i_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (valid_i),
    .ready_i  (ready_i),
    .flush_i  (flush_i),
    .bubble_i (bubble_i),
    .valid_o  (valid_o),
    .advance_o(advance),
    .flush_o  (),
    .bubble_o (),
    .accept_o (ready_o)
  );

  // Low slice of the remaining multiplier selects this stage's partial product
  assign slice = tok_i.b_rem[`MUL_SLICE-1:0];
  assign part  = tok_i.a_sh * {{(2*`MUL_W-`MUL_SLICE){1'b0}}, slice};

  always_ff @(posedge clk) begin
    if (advance) begin
      tok_q.op    <= tok_i.op;
      tok_q.tag   <= tok_i.tag;
      tok_q.acc   <= tok_i.acc + part;
      tok_q.a_sh  <= tok_i.a_sh << `MUL_SLICE;
      tok_q.b_rem <= tok_i.b_rem >> `MUL_SLICE;
    end
  end

  assign tok_o = tok_q;

endmodule

//--- rtl/mul_issue.sv
`timescale 1ns/1ps
`include "mul_consts.svh"

module mul_issue
  import mul_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush_i,
  input  logic     cancel_i,
  input  logic     req_valid_i,
  input  mul_req_t req_i,
  output logic     req_ready_o,
  output logic     tok_valid_o,
  output logic     tok_bubble_o,
  output mul_tok_t tok_o,
  input  logic     tok_ready_i
);

  issue_state_e state_q;
  mul_req_t     ent_q [2];
  logic [1:0]   cxl_q;
  logic         rd_ptr_q;
  logic         wr_ptr_q;
  logic         head_fresh_q;
  logic         push;
  logic         pop;
  mul_req_t     head;

  assign head = ent_q[rd_ptr_q];

  // A head written on the last edge waits one cycle before it is offered
  assign tok_valid_o  = (state_q != ISS_EMPTY) && !head_fresh_q;
  assign tok_bubble_o = tok_valid_o && (cxl_q[rd_ptr_q] || cancel_i);
  assign pop          = tok_valid_o && tok_ready_i;
  assign req_ready_o  = (state_q != ISS_TWO) || pop;
  assign push         = req_valid_i && req_ready_o;

  // Starting token: nothing accumulated, full multiplier still to use
  always_comb begin
    tok_o       = '0;
    tok_o.op    = head.op;
    tok_o.tag   = head.tag;
    tok_o.a_sh  = {{`MUL_W{1'b0}}, head.a};
    tok_o.b_rem = head.b;
  end

  always_ff @(posedge clk) begin
    if (push) begin
      ent_q[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      state_q      <= ISS_EMPTY;
      rd_ptr_q     <= 1'b0;
      wr_ptr_q     <= 1'b0;
      cxl_q        <= 2'b00;
      head_fresh_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q        <= !wr_ptr_q;
        cxl_q[wr_ptr_q] <= 1'b0;
      end
      // A popping head under cancel already left as a bubble
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end else if (cancel_i && state_q != ISS_EMPTY) begin
        cxl_q[rd_ptr_q] <= 1'b1;
      end
      case ({push, pop})
        2'b10:   state_q <= (state_q == ISS_EMPTY) ? ISS_ONE : ISS_TWO;
        2'b01:   state_q <= (state_q == ISS_TWO) ? ISS_ONE : ISS_EMPTY;
        default: state_q <= state_q;
      endcase
      // New entry becomes head right away only when nothing is ahead of it
      head_fresh_q <= push && (state_q == ISS_EMPTY || (state_q == ISS_ONE && pop));
    end
  end

endmodule

//--- rtl/pipe_stage_ctrl.sv
`timescale 1ns/1ps

module pipe_stage_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_i,
  input  logic ready_i,
  input  logic flush_i,
  input  logic bubble_i,
  output logic valid_o,
  output logic advance_o,
  output logic flush_o,
  output logic bubble_o,
  output logic accept_o
);

  logic valid_q;
  logic can_accept;

  // Stage is free, or its contents leave this cycle
  assign can_accept = !valid_q || ready_i;

  // Flush wins over bubble, bubble wins over advance
  assign flush_o   = flush_i;
  assign bubble_o  = !flush_i && bubble_i && can_accept;
  assign advance_o = !flush_i && !bubble_i && valid_i && can_accept;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (flush_o || bubble_o) begin
      valid_q <= 1'b0;
    end else if (advance_o) begin
      valid_q <= 1'b1;
    end else if (can_accept) begin
      valid_q <= 1'b0;
    end
  end

  assign valid_o  = valid_q;
  assign accept_o = can_accept;

endmodule

//--- rtl/mul_pkg.sv
`include "mul_consts.svh"

package mul_pkg;

  typedef enum logic [1:0] {
    MUL_LO = 2'd0,
    MUL_HI = 2'd1
  } mul_op_e;

  // Fill level of the issue buffer
  typedef enum logic [1:0] {
    ISS_EMPTY = 2'd0,
    ISS_ONE   = 2'd1,
    ISS_TWO   = 2'd2
  } issue_state_e;

  typedef struct packed {
    mul_op_e                op;
    logic [`MUL_TAG_W-1:0]  tag;
    logic [`MUL_W-1:0]      a;
    logic [`MUL_W-1:0]      b;
  } mul_req_t;

  // Shift-and-add state carried from stage to stage
  typedef struct packed {
    mul_op_e                op;
    logic [`MUL_TAG_W-1:0]  tag;
    logic [2*`MUL_W-1:0]    a_sh;
    logic [`MUL_W-1:0]      b_rem;
    logic [2*`MUL_W-1:0]    acc;
  } mul_tok_t;

  typedef struct packed {
    mul_op_e                op;
    logic [`MUL_TAG_W-1:0]  tag;
    logic [`MUL_W-1:0]      result;
  } mul_rsp_t;

endpackage

//--- rtl/mul_consts.svh
`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// Operand width of a and b
`define MUL_W 16

// Multiplier bits consumed by each stage
`define MUL_SLICE 4

// MUL_W / MUL_SLICE
`define MUL_STAGES 4

// Request tag width
`define MUL_TAG_W 4

`endif
